// File: include/adc_cfg.svh
`ifndef ADC_CFG_SVH
`define ADC_CFG_SVH

// LTC1864 style converter, 16 bit result shifted out MSB first
`define ADC_BITS    16  // bits per conversion word

// conv must stay high long enough for the conversion to finish
`define CONV_CYCLES 4   // conv high time in clkadc cycles

// conversion periods in clkadc cycles
// both must exceed CONV_CYCLES + 2*ADC_BITS + 2 so the readout
// and the ready strobe finish before the next conv
`define CUR_PERIOD  48  // motor current loop
`define POT_PERIOD  96  // pot loop, half the current rate

`endif

// File: design/adc_pkg.sv
`include "adc_cfg.svh"

package adc_pkg;

    // one reading from one converter
    typedef logic [`ADC_BITS-1:0] adc_word_t;

    // miso lines of one chain, bit 0 belongs to adc 1
    typedef logic [3:0] miso_t;

    // frame counter, wraps at 255
    typedef logic [7:0] frame_seq_t;

    // conversion sequencer states
    typedef enum logic [1:0] {
        CONV,   // conv high, adc converting
        SHIFT,  // sclk toggling, bits coming out
        WAIT    // idle until period wraps
    } spi_state_t;

endpackage

// File: design/spi_timing.sv
`timescale 1ns/1ps
`include "adc_cfg.svh"

module spi_timing #(
    parameter int PERIOD = `CUR_PERIOD          // clocks per conversion
) (
    input  logic clkadc,                        // adc clock
    input  logic rst,                           // sync reset, active high
    output logic sclk,                          // serial clock to the adcs
    output logic conv,                          // conversion start to the adcs
    output logic latch_bit,                     // shifter samples miso
    output logic latch_word,                    // shifter copies words out
    output logic ready                          // new words on shifter outputs
);
    import adc_pkg::*;

    localparam int CW        = $clog2(PERIOD);         // period counter width
    localparam int HALF_BITS = 2 * `ADC_BITS;          // sclk low + high per bit
    localparam int BW        = $clog2(HALF_BITS);      // half bit counter width

    spi_state_t    state;       // sequencer state
    logic [CW-1:0] cnt;         // position within the period
    logic [BW-1:0] bit_cnt;     // half sclk periods within SHIFT
    logic          cnt_wrap;    // last clock of the period
    logic          conv_done;   // last clock of conv high
    logic          shift_done;  // last sclk high phase

    assign cnt_wrap   = (cnt == CW'(PERIOD - 1));
    assign conv_done  = (state == CONV) && (cnt == CW'(`CONV_CYCLES - 1));
    assign shift_done = (state == SHIFT) && (bit_cnt == BW'(HALF_BITS - 1));

    // period counter
    // reset parks it on the last count, so the first free edge lands on 0
    // and conv goes high in the first cycle out of reset
    always_ff @(posedge clkadc) begin
        if (rst) begin
            cnt <= CW'(PERIOD - 1);
        end else if (cnt_wrap) begin
            cnt <= '0;                          // start next conversion
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge clkadc) begin
        if (rst) begin
            state <= WAIT;                      // matches parked counter
        end else if (cnt_wrap) begin
            state <= CONV;                      // count 0 opens conv
        end else if (conv_done) begin
            state <= SHIFT;                     // conv falls, adc drives MSB
        end else if (shift_done) begin
            state <= WAIT;                      // all bits read
        end
    end

    // odd counts are sclk high, even counts sclk low
    always_ff @(posedge clkadc) begin
        if (rst || state != SHIFT) begin
            bit_cnt <= '0;
        end else begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    assign conv      = (state == CONV);
    assign sclk      = (state == SHIFT) && bit_cnt[0];   // low then high per bit
    assign latch_bit = sclk;                    // miso stable while sclk high

    // word strobe one clock after the last bit, ready one clock later
    // when the shifter outputs already hold the new words
    always_ff @(posedge clkadc) begin
        if (rst) begin
            latch_word <= 1'b0;
            ready      <= 1'b0;
        end else begin
            latch_word <= shift_done;
            ready      <= latch_word;
        end
    end

    // no sclk while converting, and readout opens with sclk low
    a_conv_sclk: assert property (
        @(posedge clkadc) disable iff (rst) (conv || $past(conv)) |-> !sclk
    ) else $error("spi_timing: sclk high during or right after conv");

    // shifter copies each word exactly once
    a_word_pulse: assert property (
        @(posedge clkadc) disable iff (rst) latch_word |=> !latch_word
    ) else $error("spi_timing: latch_word longer than one cycle");

endmodule

// File: design/adc_shift_x4.sv
`timescale 1ns/1ps
`include "adc_cfg.svh"

module adc_shift_x4 (
    input  logic               clkadc,      // adc clock
    input  logic               rst,         // sync reset, active high
    input  adc_pkg::miso_t     miso,        // one line per adc
    input  logic               latch_bit,   // shift miso in
    input  logic               latch_word,  // copy words to outputs
    output adc_pkg::adc_word_t out1,        // adc 1 reading
    output adc_pkg::adc_word_t out2,        // adc 2 reading
    output adc_pkg::adc_word_t out3,        // adc 3 reading
    output adc_pkg::adc_word_t out4         // adc 4 reading
);
    import adc_pkg::*;

    adc_word_t sr [4];          // shift registers, filled MSB first
    adc_word_t word_q [4];      // last complete words

    // each latch_bit moves one bit in at the LSB end
    // after ADC_BITS shifts the first bit sits at the MSB
    always_ff @(posedge clkadc) begin
        if (latch_bit) begin
            for (int i = 0; i < 4; i++) begin
                sr[i] <= {sr[i][`ADC_BITS-2:0], miso[i]};
            end
        end
    end

    // outputs hold until the next conversion completes
    always_ff @(posedge clkadc) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                word_q[i] <= '0;                // zero until first word
            end
        end else if (latch_word) begin
            for (int i = 0; i < 4; i++) begin
                word_q[i] <= sr[i];
            end
        end
    end

    assign out1 = word_q[0];
    assign out2 = word_q[1];
    assign out3 = word_q[2];
    assign out4 = word_q[3];

    // word copy must not race a shift, or the last bit is lost
    a_bit_word: assert property (
        @(posedge clkadc) disable iff (rst) !(latch_bit && latch_word)
    ) else $error("adc_shift_x4: latch_bit and latch_word together");

endmodule

// File: design/fb_frame_merge.sv
`timescale 1ns/1ps

module fb_frame_merge (
    input  logic                clkadc,         // adc clock
    input  logic                rst,            // sync reset, active high
    input  logic                pot_ready,      // new pot words this cycle
    input  logic                cur_ready,      // new current words this cycle
    input  adc_pkg::adc_word_t  pot_in1,        // pot chain words
    input  adc_pkg::adc_word_t  pot_in2,
    input  adc_pkg::adc_word_t  pot_in3,
    input  adc_pkg::adc_word_t  pot_in4,
    input  adc_pkg::adc_word_t  cur_in1,        // current chain words
    input  adc_pkg::adc_word_t  cur_in2,
    input  adc_pkg::adc_word_t  cur_in3,
    input  adc_pkg::adc_word_t  cur_in4,
    output adc_pkg::adc_word_t  pot1,           // frame pot words
    output adc_pkg::adc_word_t  pot2,
    output adc_pkg::adc_word_t  pot3,
    output adc_pkg::adc_word_t  pot4,
    output adc_pkg::adc_word_t  cur1,           // frame current words
    output adc_pkg::adc_word_t  cur2,
    output adc_pkg::adc_word_t  cur3,
    output adc_pkg::adc_word_t  cur4,
    output logic                frame_valid,    // one cycle per frame
    output adc_pkg::frame_seq_t frame_seq,      // frame number
    output logic                pot_fresh       // pot words new since last frame
);
    import adc_pkg::*;

    logic       pot_pending;    // pot conversion since last frame
    frame_seq_t seq_cnt;        // number for the next frame

    // payload snapshot, taken on the current conversion
    // pot inputs hold the newest pot words, so a pot_ready in the same
    // cycle is already visible on them
    always_ff @(posedge clkadc) begin
        if (cur_ready) begin
            cur1 <= cur_in1;
            cur2 <= cur_in2;
            cur3 <= cur_in3;
            cur4 <= cur_in4;
            pot1 <= pot_in1;
            pot2 <= pot_in2;
            pot3 <= pot_in3;
            pot4 <= pot_in4;
        end
    end

    always_ff @(posedge clkadc) begin
        if (rst) begin
            pot_pending <= 1'b0;
            pot_fresh   <= 1'b0;
            frame_valid <= 1'b0;
            frame_seq   <= '0;
            seq_cnt     <= '0;                  // first frame carries 0
        end else begin
            frame_valid <= cur_ready;           // publish one clock later
            if (cur_ready) begin
                pot_fresh   <= pot_pending | pot_ready;
                pot_pending <= 1'b0;            // consumed by this frame
                frame_seq   <= seq_cnt;
                seq_cnt     <= seq_cnt + 1'b1;  // wraps at 255
            end else if (pot_ready) begin
                pot_pending <= 1'b1;            // wait for next frame
            end
        end
    end

    // cur_ready is a strobe, frames never run back to back
    a_frame_pulse: assert property (
        @(posedge clkadc) disable iff (rst) frame_valid |=> !frame_valid
    ) else $error("fb_frame_merge: frame_valid longer than one cycle");

endmodule

// File: design/adc_ctrl.sv
`timescale 1ns/1ps
`include "adc_cfg.svh"

module adc_ctrl (
    input  logic                clkadc,         // adc clock
    input  logic                rst,            // sync reset, active high
    output logic                sclk_pot,       // pot chain serial clock
    output logic                conv_pot,       // pot chain conv
    input  adc_pkg::miso_t      miso_pot,       // pot chain data lines
    output logic                sclk_cur,       // current chain serial clock
    output logic                conv_cur,       // current chain conv
    input  adc_pkg::miso_t      miso_cur,       // current chain data lines
    output adc_pkg::adc_word_t  pot1,           // pot axis 1
    output adc_pkg::adc_word_t  pot2,           // pot axis 2
    output adc_pkg::adc_word_t  pot3,           // pot axis 3
    output adc_pkg::adc_word_t  pot4,           // pot axis 4
    output adc_pkg::adc_word_t  cur1,           // current axis 1
    output adc_pkg::adc_word_t  cur2,           // current axis 2
    output adc_pkg::adc_word_t  cur3,           // current axis 3
    output adc_pkg::adc_word_t  cur4,           // current axis 4
    output logic                frame_valid,    // new feedback frame
    output adc_pkg::frame_seq_t frame_seq,      // frame number
    output logic                pot_fresh       // pot words new in frame
);
    import adc_pkg::*;

    logic      pot_latch_bit;           // pot chain strobes
    logic      pot_latch_word;
    logic      pot_ready;
    logic      cur_latch_bit;           // current chain strobes
    logic      cur_latch_word;
    logic      cur_ready;
    adc_word_t pot_w1, pot_w2, pot_w3, pot_w4;  // raw pot words
    adc_word_t cur_w1, cur_w2, cur_w3, cur_w4;  // raw current words

    // pot chain, slow loop
    spi_timing #(.PERIOD(`POT_PERIOD)) spi_pot (
        .clkadc     (clkadc),
        .rst        (rst),
        .sclk       (sclk_pot),
        .conv       (conv_pot),
        .latch_bit  (pot_latch_bit),
        .latch_word (pot_latch_word),
        .ready      (pot_ready)
    );

    adc_shift_x4 adc_pot (
        .clkadc     (clkadc),
        .rst        (rst),
        .miso       (miso_pot),
        .latch_bit  (pot_latch_bit),
        .latch_word (pot_latch_word),
        .out1       (pot_w1),
        .out2       (pot_w2),
        .out3       (pot_w3),
        .out4       (pot_w4)
    );

    // current chain, twice the pot rate
    spi_timing #(.PERIOD(`CUR_PERIOD)) spi_cur (
        .clkadc     (clkadc),
        .rst        (rst),
        .sclk       (sclk_cur),
        .conv       (conv_cur),
        .latch_bit  (cur_latch_bit),
        .latch_word (cur_latch_word),
        .ready      (cur_ready)
    );

    adc_shift_x4 adc_cur (
        .clkadc     (clkadc),
        .rst        (rst),
        .miso       (miso_cur),
        .latch_bit  (cur_latch_bit),
        .latch_word (cur_latch_word),
        .out1       (cur_w1),
        .out2       (cur_w2),
        .out3       (cur_w3),
        .out4       (cur_w4)
    );

    // frames follow the current loop
    fb_frame_merge merge0 (
        .clkadc      (clkadc),
        .rst         (rst),
        .pot_ready   (pot_ready),
        .cur_ready   (cur_ready),
        .pot_in1     (pot_w1),
        .pot_in2     (pot_w2),
        .pot_in3     (pot_w3),
        .pot_in4     (pot_w4),
        .cur_in1     (cur_w1),
        .cur_in2     (cur_w2),
        .cur_in3     (cur_w3),
        .cur_in4     (cur_w4),
        .pot1        (pot1),
        .pot2        (pot2),
        .pot3        (pot3),
        .pot4        (pot4),
        .cur1        (cur1),
        .cur2        (cur2),
        .cur3        (cur3),
        .cur4        (cur4),
        .frame_valid (frame_valid),
        .frame_seq   (frame_seq),
        .pot_fresh   (pot_fresh)
    );

endmodule

// File: bench/tb_adc_ctrl.sv
`timescale 1ns/1ps
`include "adc_cfg.svh"

module tb_adc_ctrl;
    import adc_pkg::*;

    typedef logic [3:0][`ADC_BITS-1:0] word_set_t;  // index 0 is adc 1

    logic       clkadc;
    logic       rst;
    miso_t      miso_pot;
    miso_t      miso_cur;
    logic       sclk_pot, conv_pot;
    logic       sclk_cur, conv_cur;
    adc_word_t  pot1, pot2, pot3, pot4;
    adc_word_t  cur1, cur2, cur3, cur4;
    logic       frame_valid;
    frame_seq_t frame_seq;
    logic       pot_fresh;

    word_set_t  pot_q [$];          // pot conversions from the data file
    word_set_t  cur_q [$];          // current conversions from the data file
    word_set_t  pot_sent;           // words last shifted out, pot chain
    word_set_t  cur_sent;           // words last shifted out, current chain
    bit         pot_new;            // pot set loaded since the last frame
    int         cur_loads;          // current sets taken from the queue
    int         pot_idx, cur_idx;   // bit on the miso lines
    bit         pot_conv_q, cur_conv_q;

    int         n_frames;           // one frame per current line
    int         frames;
    int         cycle;
    int         cycle_limit = 1000;
    int         first_conv_cycle = -1;
    int         last_frame_cycle;
    int         checks;
    int         errors;
    bit         conv_seen;

    int         conv_len [2];       // per chain, 0 pot and 1 current
    int         sclk_rises [2];
    bit         conv_prev [2];
    bit         sclk_prev [2];
    bit         pulse_seen [2];

    adc_ctrl dut0 (
        .clkadc      (clkadc),
        .rst         (rst),
        .sclk_pot    (sclk_pot),
        .conv_pot    (conv_pot),
        .miso_pot    (miso_pot),
        .sclk_cur    (sclk_cur),
        .conv_cur    (conv_cur),
        .miso_cur    (miso_cur),
        .pot1        (pot1),
        .pot2        (pot2),
        .pot3        (pot3),
        .pot4        (pot4),
        .cur1        (cur1),
        .cur2        (cur2),
        .cur3        (cur3),
        .cur4        (cur4),
        .frame_valid (frame_valid),
        .frame_seq   (frame_seq),
        .pot_fresh   (pot_fresh)
    );

    initial begin
        clkadc = 1'b0;
        forever #10 clkadc = ~clkadc;               // 20 ns period
    end

    initial begin
        rst      = 1'b1;
        miso_pot = '0;
        miso_cur = '0;
        repeat (2) @(posedge clkadc);
        rst <= 1'b0;
    end

    // one bit of each adc word, packed as the four miso lines
    function automatic miso_t bits_of(input word_set_t set, input int idx);
        miso_t m;
        for (int i = 0; i < 4; i++) begin
            m[i] = set[i][idx];
        end
        return m;
    endfunction

    task automatic finish_run();
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    task automatic check_word(input string name, input logic [`ADC_BITS-1:0] got,
                              input logic [`ADC_BITS-1:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("error: %s got %h expected %h in frame %0d", name, got, exp, frames);
        end
    endtask

    initial begin
        int        fd;
        int        n;
        byte       kind;
        string     line;
        adc_word_t w1, w2, w3, w4;
        fd = $fopen("bench/adc_tests.dat", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open bench/adc_tests.dat");
            finish_run();
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                n = $sscanf(line, "%c %h %h %h %h", kind, w1, w2, w3, w4);
                if (n == 5 && kind == "p") begin
                    pot_q.push_back({w4, w3, w2, w1});
                end else if (n == 5 && kind == "c") begin
                    cur_q.push_back({w4, w3, w2, w1});
                end                                 // comments and blanks skipped
            end
            $fclose(fd);
            n_frames    = cur_q.size();
            cycle_limit = (n_frames + 2) * `CUR_PERIOD;  // reset slack included
            $display("%0d pot sets, %0d current sets", pot_q.size(), n_frames);
        end
    end

    // pot adc model, MSB out after conv falls, next bit after each sclk high
    always @(posedge clkadc) begin
        if (rst) begin
            pot_conv_q = 1'b0;
            pot_idx    = 0;
            miso_pot  <= '0;
        end else begin
            if (pot_conv_q && !conv_pot) begin      // conv fell at the last edge
                if (pot_q.size() > 0) begin
                    pot_sent = pot_q.pop_front();
                end else begin
                    pot_sent = '0;                  // out of test words
                end
                pot_new  = 1'b1;
                pot_idx  = `ADC_BITS - 1;
                miso_pot <= bits_of(pot_sent, pot_idx);
            end else if (sclk_pot && pot_idx > 0) begin
                pot_idx--;
                miso_pot <= bits_of(pot_sent, pot_idx);
            end
            pot_conv_q = conv_pot;
        end
    end

    // current adc model, same protocol
    always @(posedge clkadc) begin
        if (rst) begin
            cur_conv_q = 1'b0;
            cur_idx    = 0;
            miso_cur  <= '0;
        end else begin
            if (cur_conv_q && !conv_cur) begin
                if (cur_q.size() > 0) begin
                    cur_sent = cur_q.pop_front();
                    cur_loads++;
                end else begin
                    cur_sent = '0;
                end
                cur_idx  = `ADC_BITS - 1;
                miso_cur <= bits_of(cur_sent, cur_idx);
            end else if (sclk_cur && cur_idx > 0) begin
                cur_idx--;
                miso_cur <= bits_of(cur_sent, cur_idx);
            end
            cur_conv_q = conv_cur;
        end
    end

    // conv pulse length, sclk count per readout, no sclk during conv
    task automatic watch_waveform(input int ch, input logic conv_now, input logic sclk_now);
        string name;
        name = (ch == 0) ? "pot" : "current";
        checks++;
        assert (!(conv_now && sclk_now)) else begin
            errors++;
            $display("%s chain: sclk high while conv was high", name);
        end
        if (conv_now && !conv_prev[ch]) begin       // conv rise
            if (pulse_seen[ch]) begin
                checks++;
                assert (sclk_rises[ch] == `ADC_BITS) else begin
                    errors++;
                    $display("error: %s sclk rises got %h expected %h",
                             name, sclk_rises[ch], `ADC_BITS);
                end
            end
            if (ch == 1 && first_conv_cycle < 0) begin
                first_conv_cycle = cycle;           // reference for first frame
            end
            conv_len[ch] = 0;
        end
        if (conv_now) begin
            conv_len[ch]++;
        end
        if (!conv_now && conv_prev[ch]) begin       // conv fall
            checks++;
            assert (conv_len[ch] == `CONV_CYCLES) else begin
                errors++;
                $display("error: %s conv length got %h expected %h",
                         name, conv_len[ch], `CONV_CYCLES);
            end
            sclk_rises[ch] = 0;
            pulse_seen[ch] = 1'b1;
        end
        if (sclk_now && !sclk_prev[ch]) begin
            sclk_rises[ch]++;
        end
        conv_prev[ch] = conv_now;
        sclk_prev[ch] = sclk_now;
    endtask

    task automatic check_frame();
        checks++;
        assert (cur_loads == frames + 1) else begin
            errors++;
            $display("frame %0d has no matching current test line", frames);
        end
        check_word("cur1", cur1, cur_sent[0]);
        check_word("cur2", cur2, cur_sent[1]);
        check_word("cur3", cur3, cur_sent[2]);
        check_word("cur4", cur4, cur_sent[3]);
        check_word("pot1", pot1, pot_sent[0]);      // newest pot set sent
        check_word("pot2", pot2, pot_sent[1]);
        check_word("pot3", pot3, pot_sent[2]);
        check_word("pot4", pot4, pot_sent[3]);
        check_word("pot_fresh", 16'(pot_fresh), 16'(pot_new));
        check_word("frame_seq", 16'(frame_seq), 16'(frames[7:0]));
        checks++;
        if (frames == 0) begin
            assert (cycle - first_conv_cycle == `CONV_CYCLES + 2 * `ADC_BITS + 2) else begin
                errors++;
                $display("first frame came %0d clocks after the first conv, expected %0d",
                         cycle - first_conv_cycle, `CONV_CYCLES + 2 * `ADC_BITS + 2);
            end
        end else begin
            assert (cycle - last_frame_cycle == `CUR_PERIOD) else begin
                errors++;
                $display("frame %0d came %0d clocks after the previous one, expected %0d",
                         frames, cycle - last_frame_cycle, `CUR_PERIOD);
            end
        end
        pot_new          = 1'b0;                    // next frame needs a new load
        last_frame_cycle = cycle;
        frames++;
        if (frames == n_frames) begin
            checks++;
            assert (pot_q.size() == 0) else begin
                errors++;
                $display("%0d pot test sets were never converted", pot_q.size());
            end
            finish_run();
        end
    endtask

    // outputs sampled mid cycle, away from the edge
    always @(negedge clkadc) begin
        if (!rst) begin
            if (!conv_seen) begin
                checks++;
                assert (!frame_valid && !sclk_pot && !sclk_cur) else begin
                    errors++;
                    $display("frame_valid or sclk active before the first conv pulse");
                end
                conv_seen = conv_pot || conv_cur;
            end
            watch_waveform(0, conv_pot, sclk_pot);
            watch_waveform(1, conv_cur, sclk_cur);
            if (frame_valid) begin
                check_frame();
            end
        end
    end

    always @(posedge clkadc) begin
        cycle++;
        if (cycle > cycle_limit) begin
            errors++;
            $display("timeout after %0d cycles with %0d of %0d frames seen",
                     cycle, frames, n_frames);
            finish_run();
        end
    end

endmodule

// File: bench/adc_tests.dat
# chain (p = pot, c = current), then the adc1 adc2 adc3 adc4 words in hex
# lines of one chain are converted in file order and are also the expected words

# pot chain, one set per pot conversion
p 1234 5678 9abc def0
p ffff 0000 ffff 0000
p 8001 4002 2004 1008
p a5a5 5a5a c3c3 3c3c
p 0f0f f0f0 00ff ff00
p 7fff 8000 0001 fffe

# current chain, one set per frame
c 0001 0002 0004 0008
c 8000 4000 2000 1000
c ffff ffff ffff ffff
c 0000 0000 0000 0000
c dead beef cafe f00d
c 1357 2468 9bdf ace0
c aaaa 5555 aaaa 5555
c 0123 4567 89ab cdef
c fedc ba98 7654 3210
c 8421 4218 2184 1842
c 3333 cccc 6666 9999
c 7e81 817e 00f0 0f00

// File: sim.f
+incdir+include
design/adc_pkg.sv
design/spi_timing.sv
design/adc_shift_x4.sv
design/fb_frame_merge.sv
design/adc_ctrl.sv
bench/tb_adc_ctrl.sv

// File: Makefile
# Verilator build and run of the adc_ctrl testbench

VERILATOR ?= verilator
TOP       ?= tb_adc_ctrl
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# build, run, then pass only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
